//--- predictor_config.svh
`ifndef PREDICTOR_CONFIG_SVH
`define PREDICTOR_CONFIG_SVH

// Return stack slots, must be a power of two so the index wraps
`define RETURN_SIZE 8

// Recovery queue entries, also a power of two
`define RETURN_RQ_SIZE 8

// Direct-mapped BTB lines
`define BTB_ENTRIES 16

// Fetch block tag and 2-byte slot offset widths
`define FETCH_ID_BITS 4
`define FETCH_OFF_BITS 2

`endif

//--- fetchTypesPkg.sv
`default_nettype none

`include "predictor_config.svh"

package fetchTypesPkg;

    // Wrapping tag of a fetch block
    // There is no extra range bit, so two IDs are only ordered relative to a base
    typedef logic [`FETCH_ID_BITS-1:0] FetchId;

    // Halfword slot inside a fetch block
    typedef logic [`FETCH_OFF_BITS-1:0] FetchOff;

endpackage

`default_nettype wire

//--- branchTypesPkg.sv
`default_nettype none

`include "predictor_config.svh"

package branchTypesPkg;

    // Kind of control transfer stored in a BTB line
    typedef enum logic [1:0] {
        BK_NONE   = 2'd0,
        BK_CALL   = 2'd1,
        BK_RETURN = 2'd2
    } BranchKind;

    // Slot of the circular return stack
    typedef logic [$clog2(`RETURN_SIZE)-1:0] RetStackIdx;

endpackage

`default_nettype wire

//--- branchTargetBuffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "predictor_config.svh"

module branchTargetBuffer
    import fetchTypesPkg::*;
    import branchTypesPkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            fetchValid,
    input  wire [30:0]     fetchPc,
    input  wire FetchId    fetchId,
    input  wire            flush,
    input  wire            btbWrite,
    input  wire [30:0]     btbPc,
    input  wire BranchKind btbKind,
    input  wire FetchOff   btbOffs,
    output logic           lastValid,
    output logic [30:0]    lastPc,
    output FetchId         lastId,
    output BranchKind      branchKind,
    output FetchOff        branchOffs
);

    localparam int OFF_BITS = `FETCH_OFF_BITS;
    localparam int ENTRIES  = `BTB_ENTRIES;
    localparam int IDX_BITS = $clog2(ENTRIES);
    localparam int TAG_BITS = 31 - OFF_BITS - IDX_BITS;

    logic                entryValid [ENTRIES];
    logic [TAG_BITS-1:0] entryTag   [ENTRIES];
    BranchKind           entryKind  [ENTRIES];
    FetchOff             entryOffs  [ENTRIES];

    logic [IDX_BITS-1:0] lookupIdx;
    logic [TAG_BITS-1:0] lookupTag;
    logic [IDX_BITS-1:0] writeIdx;
    logic [TAG_BITS-1:0] writeTag;
    logic                lookupHit;
    logic                accept;

    // Line index sits just above the slot offset, the rest of the block address is the tag
    assign lookupIdx = fetchPc[OFF_BITS +: IDX_BITS];
    assign lookupTag = fetchPc[30 -: TAG_BITS];
    assign writeIdx  = btbPc[OFF_BITS +: IDX_BITS];
    assign writeTag  = btbPc[30 -: TAG_BITS];

    assign lookupHit = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);

    // A block fetched while a mispredict is signalled is already squashed
    assign accept = fetchValid && !flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                entryValid[i] <= 1'b0;
            end
            lastValid  <= 1'b0;
            branchKind <= BK_NONE;
        end else begin
            if (btbWrite) begin
                entryValid[writeIdx] <= 1'b1;
            end
            lastValid <= accept;
            // Kind is forced to none for any cycle without a live lookup result
            if (accept && lookupHit) begin
                branchKind <= entryKind[lookupIdx];
            end else begin
                branchKind <= BK_NONE;
            end
        end
    end

    // Table contents and the lookup payload
    always_ff @(posedge clk) begin
        if (btbWrite) begin
            entryTag[writeIdx]  <= writeTag;
            entryKind[writeIdx] <= btbKind;
            entryOffs[writeIdx] <= btbOffs;
        end
        if (fetchValid) begin
            lastPc     <= fetchPc;
            lastId     <= fetchId;
            branchOffs <= entryOffs[lookupIdx];
        end
    end

    // The return stack treats a branch kind as live without checking lastValid again
    kindNeedsValid: assert property (
        @(posedge clk) disable iff (rst)
        !lastValid |-> branchKind == BK_NONE
    ) else $error("BTB reports a branch without a valid block");

endmodule

`default_nettype wire

//--- returnStack.sv
`default_nettype none
`timescale 1ns/1ps

`include "predictor_config.svh"

module returnStack
    import fetchTypesPkg::*;
    import branchTypesPkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             fetchValid,
    input  wire             lastValid,
    input  wire [30:0]      lastPc,
    input  wire FetchId     lastId,
    input  wire BranchKind  branchKind,
    input  wire FetchOff    branchOffs,
    input  wire             misprValid,
    input  wire FetchId     misprId,
    input  wire FetchOff    misprOffs,
    input  wire RetStackIdx recoveryIdx,
    input  wire FetchId     commitId,
    output logic            stall,
    output logic            predValid,
    output logic [30:0]     retAddr,
    output RetStackIdx      retIdx
);

    localparam int SIZE     = `RETURN_SIZE;
    localparam int RQ_SIZE  = `RETURN_RQ_SIZE;
    localparam int OFF_BITS = `FETCH_OFF_BITS;
    localparam int Q_BITS   = $clog2(RQ_SIZE);
    localparam int PTR_W    = Q_BITS + 1;

    logic [30:0] stackMem [SIZE];

    // Recovery queue, one entry per call, holding what that call overwrote
    logic [30:0] qAddr [RQ_SIZE];
    RetStackIdx  qIdx  [RQ_SIZE];
    FetchId      qId   [RQ_SIZE];
    FetchOff     qOffs [RQ_SIZE];

    // Pointers carry one extra bit to tell a full queue from an empty one
    logic [PTR_W-1:0]  qHead;
    logic [PTR_W-1:0]  qTail;
    logic [PTR_W-1:0]  qCount;
    logic [Q_BITS-1:0] newestPtr;
    logic [Q_BITS-1:0] oldestPtr;
    logic [Q_BITS-1:0] headPtr;
    logic              queueEmpty;
    logic              queueFull;

    RetStackIdx  rindexReg;
    RetStackIdx  rindex;
    logic [30:0] pushAddr;
    logic        isCall;
    logic        isReturn;
    logic        doPush;

    logic    recovering;
    FetchId  recId;
    FetchId  recBase;
    FetchOff recOffs;
    FetchId  queueRel;
    FetchId  recRel;
    logic    recContinue;
    logic    doRestore;

    FetchId lastRetId;
    FetchId tailRel;
    FetchId commitRel;
    logic   retireCheck;

    assign headPtr    = qHead[Q_BITS-1:0];
    assign newestPtr  = headPtr - Q_BITS'(1);
    assign oldestPtr  = qTail[Q_BITS-1:0];
    assign qCount     = qHead - qTail;
    assign queueEmpty = (qHead == qTail);
    assign queueFull  = (qHead == qTail + PTR_W'(RQ_SIZE));

    assign isCall   = lastValid && (branchKind == BK_CALL);
    assign isReturn = lastValid && (branchKind == BK_RETURN);

    // Return lands on the slot after the call
    assign pushAddr = {lastPc[30:OFF_BITS], branchOffs} + 31'd1;

    // Index after the previous block's call or return, used in this same cycle
    always_comb begin
        rindex = rindexReg;
        if (isCall) begin
            rindex = rindexReg + RetStackIdx'(1);
        end else if (isReturn) begin
            rindex = rindexReg - RetStackIdx'(1);
        end
    end

    assign doPush = !misprValid && !recovering && isCall;

    // Walk back while the newest entry was written after the mispredicting slot.
    // The mispredicting slot itself is not undone
    always_comb begin
        queueRel    = qId[newestPtr] - recBase;
        recRel      = recId - recBase;
        recContinue = !queueEmpty &&
                      ((queueRel > recRel) ||
                       ((queueRel == recRel) && (qOffs[newestPtr] > recOffs)));
    end

    assign doRestore = !misprValid && recovering && recContinue;
    assign stall     = recovering;

    // Commit ordering is measured from the ID retired last
    always_comb begin
        tailRel     = qId[oldestPtr] - lastRetId;
        commitRel   = commitId - lastRetId;
        retireCheck = !misprValid && !recovering && (lastRetId != commitId);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SIZE; i++) begin
                stackMem[i] <= 31'd0;
            end
            qHead      <= '0;
            qTail      <= '0;
            rindexReg  <= '0;
            recovering <= 1'b0;
            predValid  <= 1'b0;
            lastRetId  <= '0;
        end else begin
            if (misprValid) begin
                rindexReg  <= recoveryIdx;
                recovering <= !queueEmpty;
                predValid  <= 1'b0;
            end else begin
                rindexReg <= rindex;
                if (fetchValid) begin
                    predValid <= 1'b1;
                end
            end

            if (doRestore) begin
                stackMem[qIdx[newestPtr]] <= qAddr[newestPtr];
                qHead                     <= qHead - PTR_W'(1);
            end else if (!misprValid && recovering) begin
                // Newest entry is older than the mispredict, so the walk is done
                recovering <= 1'b0;
            end

            // A call on a full queue still pushes, only its undo record is lost
            if (doPush) begin
                stackMem[rindex] <= pushAddr;
                if (!queueFull) begin
                    qHead <= qHead + PTR_W'(1);
                end
            end

            // At most one entry is freed per cycle until the commit point is reached
            if (retireCheck) begin
                if (!queueEmpty && (tailRel < commitRel)) begin
                    lastRetId <= qId[oldestPtr];
                    qTail     <= qTail + PTR_W'(1);
                end else begin
                    lastRetId <= commitId;
                end
            end
        end
    end

    // Queue contents and the prediction output
    always_ff @(posedge clk) begin
        if (doPush && !queueFull) begin
            qAddr[headPtr] <= stackMem[rindex];
            qIdx[headPtr]  <= rindex;
            qId[headPtr]   <= lastId;
            qOffs[headPtr] <= branchOffs;
        end
        if (misprValid) begin
            recId   <= misprId;
            recBase <= commitId;
            recOffs <= misprOffs;
        end
        if (fetchValid && !misprValid) begin
            retIdx <= rindex;
            // A call in the block just before has not reached the stack yet
            if (isCall) begin
                retAddr <= pushAddr;
            end else begin
                retAddr <= stackMem[rindex];
            end
        end
    end

    // The BTB flush must keep squashed calls away from a running recovery
    noCallInStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |-> !isCall
    ) else $error("Call reached the return stack during recovery");

    queueBounded: assert property (
        @(posedge clk) disable iff (rst)
        qCount <= PTR_W'(RQ_SIZE)
    ) else $error("Recovery queue underflow");

    noFetchInStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |-> !fetchValid
    ) else $error("Fetch issued a block while the return stack stalls");

endmodule

`default_nettype wire

//--- fetchPredictor.sv
`default_nettype none
`timescale 1ns/1ps

module fetchPredictor
    import fetchTypesPkg::*;
    import branchTypesPkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             fetchValid,
    input  wire [30:0]      fetchPc,
    input  wire FetchId     fetchId,
    input  wire             btbWrite,
    input  wire [30:0]      btbPc,
    input  wire BranchKind  btbKind,
    input  wire FetchOff    btbOffs,
    input  wire             misprValid,
    input  wire FetchId     misprId,
    input  wire FetchOff    misprOffs,
    input  wire RetStackIdx recoveryIdx,
    input  wire FetchId     commitId,
    output logic            stall,
    output logic            predValid,
    output logic [30:0]     retAddr,
    output RetStackIdx      retIdx
);

    // Registered BTB result of the previous fetch
    logic        lastValid;
    logic [30:0] lastPc;
    FetchId      lastId;
    BranchKind   branchKind;
    FetchOff     branchOffs;

    // A mispredict squashes the block whose lookup is still in flight
    branchTargetBuffer u_btb (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchId    (fetchId),
        .flush      (misprValid),
        .btbWrite   (btbWrite),
        .btbPc      (btbPc),
        .btbKind    (btbKind),
        .btbOffs    (btbOffs),
        .lastValid  (lastValid),
        .lastPc     (lastPc),
        .lastId     (lastId),
        .branchKind (branchKind),
        .branchOffs (branchOffs)
    );

    returnStack u_rs (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .lastValid   (lastValid),
        .lastPc      (lastPc),
        .lastId      (lastId),
        .branchKind  (branchKind),
        .branchOffs  (branchOffs),
        .misprValid  (misprValid),
        .misprId     (misprId),
        .misprOffs   (misprOffs),
        .recoveryIdx (recoveryIdx),
        .commitId    (commitId),
        .stall       (stall),
        .predValid   (predValid),
        .retAddr     (retAddr),
        .retIdx      (retIdx)
    );

endmodule

`default_nettype wire

//--- tb_fetchPredictor.sv
`default_nettype none
`timescale 1ns/1ps

`include "predictor_config.svh"

module tb_fetchPredictor
    import fetchTypesPkg::*;
    import branchTypesPkg::*;
();

    localparam int SIZE   = `RETURN_SIZE;
    localparam int LINES  = `BTB_ENTRIES;
    localparam int OFF_W  = `FETCH_OFF_BITS;
    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = 31 - OFF_W - LINE_W;
    localparam int IDS    = 1 << `FETCH_ID_BITS;
    localparam int POOL   = 8;

    logic        clk;
    logic        rst;
    logic        fetchValid;
    logic [30:0] fetchPc;
    FetchId      fetchId;
    logic        btbWrite;
    logic [30:0] btbPc;
    BranchKind   btbKind;
    FetchOff     btbOffs;
    logic        misprValid;
    FetchId      misprId;
    FetchOff     misprOffs;
    RetStackIdx  recoveryIdx;
    FetchId      commitId;
    logic        stall;
    logic        predValid;
    logic [30:0] retAddr;
    RetStackIdx  retIdx;

    // Reference copy of the BTB lines
    logic             lineValid [LINES];
    logic [TAG_W-1:0] lineTag   [LINES];
    BranchKind        lineKind  [LINES];
    FetchOff          lineOffs  [LINES];

    // Architectural stack and its state after every fetch block
    logic [30:0] refStack  [SIZE];
    RetStackIdx  refIdx;
    logic [30:0] snapStack [IDS][SIZE];
    RetStackIdx  snapIdx   [IDS];

    logic [30:0] pool [POOL];
    FetchId      nextId;
    logic [31:0] rngState;
    string       testName;
    int          testCount;
    int          checks;
    int          errors;
    int          testErrors;
    bit          hung;

    fetchPredictor u_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
        errors++;
        testErrors++;
    endtask

    task automatic reportFailure(input string msg);
        $display("%s: %s", testName, msg);
        errors++;
        testErrors++;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testCount++;
        $display("%s finished with %0d errors", testName, testErrors);
    endtask

    // Spread the pool over even lines so that no two sites share a line
    task automatic buildPool();
        logic [31:0] r;
        for (int i = 0; i < POOL; i++) begin
            r       = nextRand();
            pool[i] = {r[TAG_W-1:0], LINE_W'(2 * i), {OFF_W{1'b0}}};
        end
    endtask

    task automatic programLine(input logic [30:0] pc, input BranchKind kind,
                               input FetchOff offs);
        int line;
        line     = int'(pc[OFF_W +: LINE_W]);
        btbWrite = 1'b1;
        btbPc    = pc;
        btbKind  = kind;
        btbOffs  = offs;
        @(negedge clk);
        btbWrite        = 1'b0;
        lineValid[line] = 1'b1;
        lineTag[line]   = pc[30 -: TAG_W];
        lineKind[line]  = kind;
        lineOffs[line]  = offs;
    endtask

    // Call pushes the slot after it, return pops, a BTB miss changes nothing
    task automatic applyBlock(input logic [30:0] pc, input FetchId id);
        int line;
        line = int'(pc[OFF_W +: LINE_W]);
        if (lineValid[line] && lineTag[line] == pc[30 -: TAG_W]) begin
            if (lineKind[line] == BK_CALL) begin
                refIdx           = refIdx + RetStackIdx'(1);
                refStack[refIdx] = {pc[30:OFF_W], lineOffs[line]} + 31'd1;
            end else if (lineKind[line] == BK_RETURN) begin
                refIdx = refIdx - RetStackIdx'(1);
            end
        end
        snapIdx[id] = refIdx;
        for (int i = 0; i < SIZE; i++)
            snapStack[id][i] = refStack[i];
    endtask

    task automatic fetchBlock(input logic [30:0] pc);
        RetStackIdx  expIdx;
        logic [30:0] expAddr;
        expIdx     = refIdx;
        expAddr    = refStack[refIdx];
        fetchValid = 1'b1;
        fetchPc    = pc;
        fetchId    = nextId;
        @(negedge clk);
        fetchValid = 1'b0;
        checks += 3;
        if (predValid !== 1'b1)
            reportFailure("predValid stayed low after a fetch");
        if (retAddr !== expAddr)
            reportMismatch("retAddr", 32'(expAddr), 32'(retAddr));
        if (retIdx !== expIdx)
            reportMismatch("retIdx", 32'(expIdx), 32'(retIdx));
        applyBlock(pc, nextId);
        nextId = nextId + FetchId'(1);
    endtask

    task automatic fetchRandom();
        int pick;
        pick = int'(nextRand() % POOL);
        fetchBlock(pool[pick]);
    endtask

    // Retirement frees at most one queue entry per cycle
    task automatic commitTo(input FetchId id);
        // The newest block commits only after its BTB result has reached the stack
        @(negedge clk);
        commitId = id;
        repeat (`RETURN_RQ_SIZE + 2) @(negedge clk);
    endtask

    task automatic mispredict(input FetchId id);
        int waited;
        // One idle cycle lets the last fetched block reach the stack
        @(negedge clk);
        misprValid  = 1'b1;
        misprId     = id;
        misprOffs   = '1;
        recoveryIdx = snapIdx[id];
        @(negedge clk);
        misprValid = 1'b0;
        checks++;
        if (predValid !== 1'b0)
            reportFailure("predValid still high after a mispredict");
        refIdx = snapIdx[id];
        for (int i = 0; i < SIZE; i++)
            refStack[i] = snapStack[id][i];
        nextId = id + FetchId'(1);
        waited = 0;
        while (stall !== 1'b0 && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (stall !== 1'b0) begin
            reportFailure("stall stayed high for 64 cycles after a mispredict");
            hung = 1'b1;
        end
    endtask

    task automatic resetTest();
        startTest("reset");
        checks += 2;
        if (stall !== 1'b0)
            reportFailure("stall is high after reset");
        if (predValid !== 1'b0)
            reportFailure("predValid is high after reset");
        fetchBlock(pool[0]);
        finishTest();
    endtask

    task automatic callTest();
        int r;
        startTest("calls");
        for (int i = 0; i < POOL; i++) begin
            r = int'(nextRand() % 4);
            programLine(pool[i], r < 2 ? BK_CALL : (r == 2 ? BK_RETURN : BK_NONE),
                        FetchOff'(nextRand()));
        end
        for (int n = 0; n < 40; n++) begin
            fetchRandom();
            // A gap takes the path where the call has already reached the stack
            if (nextRand() % 3 == 0)
                @(negedge clk);
            if (n % 4 == 3)
                commitTo(nextId);
        end
        finishTest();
    endtask

    task automatic wrapTest();
        startTest("wrap");
        programLine(pool[0], BK_RETURN, '0);
        for (int n = 0; n < 2 * SIZE + 3; n++)
            fetchBlock(pool[0]);
        commitTo(nextId);
        finishTest();
    endtask

    task automatic recoveryTest();
        FetchId base;
        int     count;
        startTest("recovery");
        for (int i = 1; i < 4; i++)
            programLine(pool[i], BK_CALL, FetchOff'(nextRand()));
        for (int round = 0; round < 8; round++) begin
            base  = nextId;
            count = 3 + int'(nextRand() % 4);
            for (int n = 0; n < count; n++)
                fetchRandom();
            mispredict(base + FetchId'(nextRand() % count));
            if (hung)
                return;
            for (int n = 0; n < 3; n++)
                fetchRandom();
            commitTo(nextId);
        end
        finishTest();
    endtask

    task automatic commitTest();
        startTest("commit");
        for (int round = 0; round < 6; round++) begin
            for (int n = 0; n < 4; n++)
                fetchRandom();
            // The two newest blocks stay speculative
            commitTo(nextId - FetchId'(2));
        end
        for (int n = 0; n < 3; n++)
            fetchRandom();
        mispredict(commitId);
        if (hung)
            return;
        for (int n = 0; n < 4; n++)
            fetchRandom();
        commitTo(nextId);
        finishTest();
    endtask

    task automatic rewriteTest();
        startTest("rewrite");
        programLine(pool[3], BK_CALL, 2'd1);
        fetchBlock(pool[3]);
        fetchBlock(pool[3]);
        programLine(pool[3], BK_RETURN, 2'd1);
        fetchBlock(pool[3]);
        fetchBlock(pool[3]);
        // A new tag on the same line turns the old site into a miss
        programLine(pool[3] ^ {1'b1, 30'd0}, BK_CALL, 2'd0);
        fetchBlock(pool[3]);
        fetchBlock(pool[3]);
        commitTo(nextId);
        finishTest();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetchValid  = 1'b0;
        fetchPc     = '0;
        fetchId     = '0;
        btbWrite    = 1'b0;
        btbPc       = '0;
        btbKind     = BK_NONE;
        btbOffs     = '0;
        misprValid  = 1'b0;
        misprId     = '0;
        misprOffs   = '0;
        recoveryIdx = '0;
        commitId    = '0;
        rngState    = 32'd20;
        nextId      = '0;
        refIdx      = '0;
        testCount   = 0;
        checks      = 0;
        errors      = 0;
        testErrors  = 0;
        hung        = 1'b0;
        for (int i = 0; i < SIZE; i++)
            refStack[i] = '0;
        for (int i = 0; i < LINES; i++)
            lineValid[i] = 1'b0;
        buildPool();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        resetTest();
        callTest();
        wrapTest();
        recoveryTest();
        if (!hung)
            commitTest();
        if (!hung)
            rewriteTest();
        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
fetchTypesPkg.sv
branchTypesPkg.sv
branchTargetBuffer.sv
returnStack.sv
fetchPredictor.sv
tb_fetchPredictor.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetchPredictor \
    -f vlog.f \
    -o tb_fetchPredictor

./obj_dir/tb_fetchPredictor 2>&1 | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation finished cleanly"
